// ==== rtl/csr_pkg.sv ====
/*
  CSR package
  Addresses, write masks, reset values and the
  event type shared by the machine-mode CSR file
*/
package csr_pkg;

  localparam int unsigned xlen       = 32;  // Data width
  localparam int unsigned csr_addr_w = 12;  // CSR address width

  // ==================================================
  // CSR addresses
  // ==================================================
  // Machine information, read-only
  localparam logic [csr_addr_w-1:0] addr_mvendorid  = 12'hF11;
  localparam logic [csr_addr_w-1:0] addr_marchid    = 12'hF12;
  localparam logic [csr_addr_w-1:0] addr_mimpid     = 12'hF13;
  localparam logic [csr_addr_w-1:0] addr_mhartid    = 12'hF14;
  localparam logic [csr_addr_w-1:0] addr_mconfigptr = 12'hF15;

  // Trap setup
  localparam logic [csr_addr_w-1:0] addr_mstatus  = 12'h300;
  localparam logic [csr_addr_w-1:0] addr_misa     = 12'h301;
  localparam logic [csr_addr_w-1:0] addr_mie      = 12'h304;
  localparam logic [csr_addr_w-1:0] addr_mtvec    = 12'h305;
  localparam logic [csr_addr_w-1:0] addr_mstatush = 12'h310;  // Reads as zero

  // Trap handling
  localparam logic [csr_addr_w-1:0] addr_mscratch = 12'h340;
  localparam logic [csr_addr_w-1:0] addr_mepc     = 12'h341;
  localparam logic [csr_addr_w-1:0] addr_mcause   = 12'h342;
  localparam logic [csr_addr_w-1:0] addr_mtval    = 12'h343;
  localparam logic [csr_addr_w-1:0] addr_mip      = 12'h344;

  // Machine counters
  localparam logic [csr_addr_w-1:0] addr_mcycle    = 12'hB00;
  localparam logic [csr_addr_w-1:0] addr_minstret  = 12'hB02;
  localparam logic [csr_addr_w-1:0] addr_mcycleh   = 12'hB80;
  localparam logic [csr_addr_w-1:0] addr_minstreth = 12'hB82;

  // User-mode aliases of the counters
  localparam logic [csr_addr_w-1:0] addr_cycle    = 12'hC00;
  localparam logic [csr_addr_w-1:0] addr_instret  = 12'hC02;
  localparam logic [csr_addr_w-1:0] addr_cycleh   = 12'hC80;
  localparam logic [csr_addr_w-1:0] addr_instreth = 12'hC82;

  // ==================================================
  // Reset values and masks
  // ==================================================
  // RV32IMC: MXL=1, M bit 12, I bit 8, C bit 2
  localparam logic [xlen-1:0] misa_reset   = 32'h4000_1104;
  localparam logic [xlen-1:0] misa_wr_mask = 32'h0000_0004;  // Only C
  localparam logic [xlen-1:0] mie_wr_mask  = 32'h0000_0888;  // MSIE, MTIE, MEIE

  localparam int unsigned mstatus_mie_bit  = 3;
  localparam int unsigned mstatus_mpie_bit = 7;
  localparam int unsigned mstatus_mpp_lsb  = 11;  // Two bits, fixed at 3

  localparam int unsigned mip_msip_bit = 3;
  localparam int unsigned mip_mtip_bit = 7;
  localparam int unsigned mip_meip_bit = 11;

  localparam logic [xlen-1:0] marchid_value = 32'd5;

  // Winning event of a cycle, highest priority first after none
  typedef enum logic [1:0] {
    ev_none,
    ev_trap,
    ev_mret,
    ev_write
  } csr_event_e;

endpackage

// ==== rtl/csr_event_ctrl.sv ====
/*
  CSR event controller
  Ranks trap, mret and CSR write each cycle and
  produces the advance, write and retire strobes
*/
`timescale 1ns/1ps

module csr_event_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic stall_i,
  input  logic trap_i,
  input  logic mret_i,
  input  logic wr_en_i,
  output logic advance_o,
  output logic csr_we_o,
  output logic retire_o
);
  import csr_pkg::*;

  csr_event_e event_d;       // Winner of this cycle
  csr_event_e last_event_q;  // Previous winner

  // Trap breaks through a stall
  assign advance_o = !stall_i || trap_i;

  always_comb begin
    event_d = ev_none;
    if (trap_i) begin
      event_d = ev_trap;
    end else if (advance_o && mret_i) begin
      event_d = ev_mret;  // Beats a write
    end else if (advance_o && wr_en_i) begin
      event_d = ev_write;
    end
  end

  assign csr_we_o = (event_d == ev_write);
  assign retire_o = advance_o && (event_d != ev_trap);  // Trapped instr does not retire

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      last_event_q <= ev_none;
    end else begin
      last_event_q <= event_d;
    end
  end

endmodule

// ==== rtl/csr_trap_regs.sv ====
/*
  Trap registers
  mstatus, mepc, mcause and mtval. Applies trap
  entry, mret return and masked software writes
*/
`timescale 1ns/1ps

module csr_trap_regs (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           advance_i,
  input  logic                           csr_we_i,
  input  logic                           trap_i,
  input  logic                           mret_i,
  input  logic [csr_pkg::csr_addr_w-1:0] csr_idx_i,
  input  logic [csr_pkg::xlen-1:0]       csr_wdata_i,
  input  logic [csr_pkg::xlen-1:0]       trap_cause_i,
  input  logic [csr_pkg::xlen-1:0]       trap_mepc_i,
  input  logic [csr_pkg::xlen-1:0]       trap_tval_i,
  output logic [csr_pkg::xlen-1:0]       mstatus_o,
  output logic [csr_pkg::xlen-1:0]       mepc_o,
  output logic [csr_pkg::xlen-1:0]       mcause_o,
  output logic [csr_pkg::xlen-1:0]       mtval_o
);
  import csr_pkg::*;

  logic            mie_q;   // mstatus.MIE
  logic            mpie_q;  // mstatus.MPIE
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mcause_q;
  logic [xlen-1:0] mtval_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
      mtval_q  <= '0;
    end else if (trap_i) begin
      mepc_q   <= trap_mepc_i;
      mcause_q <= trap_cause_i;
      mtval_q  <= trap_tval_i;
      mpie_q   <= mie_q;  // Save and mask interrupts
      mie_q    <= 1'b0;
    end else if (advance_i && mret_i) begin
      mie_q  <= mpie_q;
      mpie_q <= 1'b1;
    end else if (csr_we_i) begin
      case (csr_idx_i)
        addr_mstatus: begin
          mie_q  <= csr_wdata_i[mstatus_mie_bit];  // Other bits dropped
          mpie_q <= csr_wdata_i[mstatus_mpie_bit];
        end
        addr_mepc:   mepc_q   <= csr_wdata_i;
        addr_mcause: mcause_q <= csr_wdata_i;
        addr_mtval:  mtval_q  <= csr_wdata_i;
        default: ;
      endcase
    end
  end

  // MPP hardwired to machine mode
  always_comb begin
    mstatus_o                           = '0;
    mstatus_o[mstatus_mie_bit]          = mie_q;
    mstatus_o[mstatus_mpie_bit]         = mpie_q;
    mstatus_o[mstatus_mpp_lsb +: 2]     = 2'b11;
  end

  assign mepc_o   = mepc_q;
  assign mcause_o = mcause_q;
  assign mtval_o  = mtval_q;

endmodule

// ==== rtl/csr_setup_regs.sv ====
/*
  Setup registers
  misa, mie, mtvec and mscratch with their WARL
  write masks, plus mip built from the irq lines
*/
`timescale 1ns/1ps

module csr_setup_regs (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           csr_we_i,
  input  logic [csr_pkg::csr_addr_w-1:0] csr_idx_i,
  input  logic [csr_pkg::xlen-1:0]       csr_wdata_i,
  input  logic                           timer_irq_i,
  input  logic                           sw_irq_i,
  input  logic                           ext_irq_i,
  output logic [csr_pkg::xlen-1:0]       misa_o,
  output logic [csr_pkg::xlen-1:0]       mie_o,
  output logic [csr_pkg::xlen-1:0]       mtvec_o,
  output logic [csr_pkg::xlen-1:0]       mscratch_o,
  output logic [csr_pkg::xlen-1:0]       mip_o
);
  import csr_pkg::*;

  logic [xlen-1:0] misa_q;
  logic [xlen-1:0] mie_q;
  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mscratch_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      misa_q     <= misa_reset;  // RV32IMC out of reset
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
    end else if (csr_we_i) begin
      case (csr_idx_i)
        // Masked bits keep their old value
        addr_misa:     misa_q <= (misa_q & ~misa_wr_mask) | (csr_wdata_i & misa_wr_mask);
        addr_mie:      mie_q  <= (mie_q & ~mie_wr_mask) | (csr_wdata_i & mie_wr_mask);
        addr_mtvec:    mtvec_q    <= csr_wdata_i;
        addr_mscratch: mscratch_q <= csr_wdata_i;
        default: ;
      endcase
    end
  end

  // ==================================================
  // Pending bits follow the lines directly
  // ==================================================
  always_comb begin
    mip_o               = '0;
    mip_o[mip_msip_bit] = sw_irq_i;     // Software
    mip_o[mip_mtip_bit] = timer_irq_i;  // Timer
    mip_o[mip_meip_bit] = ext_irq_i;    // External
  end

  assign misa_o     = misa_q;
  assign mie_o      = mie_q;
  assign mtvec_o    = mtvec_q;
  assign mscratch_o = mscratch_q;

endmodule

// ==== rtl/csr_counters.sv ====
/*
  Performance counters
  64-bit mcycle and minstret with per-half write
  override and retire inhibit on minstret writes
*/
`timescale 1ns/1ps

module csr_counters (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           advance_i,
  input  logic                           retire_i,
  input  logic                           csr_we_i,
  input  logic [csr_pkg::csr_addr_w-1:0] csr_idx_i,
  input  logic [csr_pkg::xlen-1:0]       csr_wdata_i,
  output logic [63:0]                    mcycle_o,
  output logic [63:0]                    minstret_o
);
  import csr_pkg::*;

  logic [63:0] mcycle_q;
  logic [63:0] minstret_q;
  logic [63:0] mcycle_inc;  // Carry into high half included
  logic        wr_mcycle;
  logic        wr_mcycleh;
  logic        wr_minstret;
  logic        wr_minstreth;

  assign mcycle_inc   = mcycle_q + 64'd1;
  assign wr_mcycle    = csr_we_i && (csr_idx_i == addr_mcycle);
  assign wr_mcycleh   = csr_we_i && (csr_idx_i == addr_mcycleh);
  assign wr_minstret  = csr_we_i && (csr_idx_i == addr_minstret);
  assign wr_minstreth = csr_we_i && (csr_idx_i == addr_minstreth);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      // Written half wins, other half still counts
      if (advance_i) begin
        mcycle_q <= mcycle_inc;
        if (wr_mcycle) mcycle_q[xlen-1:0] <= csr_wdata_i;
        if (wr_mcycleh) mcycle_q[63:xlen] <= csr_wdata_i;
      end
      // A write to either half suppresses the retire count
      if (wr_minstret) begin
        minstret_q[xlen-1:0] <= csr_wdata_i;
      end else if (wr_minstreth) begin
        minstret_q[63:xlen] <= csr_wdata_i;
      end else if (retire_i) begin
        minstret_q <= minstret_q + 64'd1;
      end
    end
  end

  assign mcycle_o   = mcycle_q;
  assign minstret_o = minstret_q;

endmodule

// ==== rtl/csr_read_mux.sv ====
/*
  CSR read mux
  Combinational address decode over every readable
  CSR. Zero when idle or for an unknown address
*/
`timescale 1ns/1ps

module csr_read_mux (
  input  logic                           rd_en_i,
  input  logic [csr_pkg::csr_addr_w-1:0] csr_idx_i,
  input  logic [csr_pkg::xlen-1:0]       mstatus_i,
  input  logic [csr_pkg::xlen-1:0]       misa_i,
  input  logic [csr_pkg::xlen-1:0]       mie_i,
  input  logic [csr_pkg::xlen-1:0]       mip_i,
  input  logic [csr_pkg::xlen-1:0]       mtvec_i,
  input  logic [csr_pkg::xlen-1:0]       mscratch_i,
  input  logic [csr_pkg::xlen-1:0]       mepc_i,
  input  logic [csr_pkg::xlen-1:0]       mcause_i,
  input  logic [csr_pkg::xlen-1:0]       mtval_i,
  input  logic [63:0]                    mcycle_i,
  input  logic [63:0]                    minstret_i,
  output logic [csr_pkg::xlen-1:0]       csr_rdata_o
);
  import csr_pkg::*;

  always_comb begin
    csr_rdata_o = '0;  // Idle or unknown
    if (rd_en_i) begin
      case (csr_idx_i)
        // Information registers, only marchid nonzero
        addr_mvendorid,
        addr_mimpid,
        addr_mhartid,
        addr_mconfigptr: csr_rdata_o = '0;
        addr_marchid:    csr_rdata_o = marchid_value;

        addr_mstatus:  csr_rdata_o = mstatus_i;
        addr_mstatush: csr_rdata_o = '0;  // Little endian only
        addr_misa:     csr_rdata_o = misa_i;
        addr_mie:      csr_rdata_o = mie_i;
        addr_mtvec:    csr_rdata_o = mtvec_i;
        addr_mscratch: csr_rdata_o = mscratch_i;
        addr_mepc:     csr_rdata_o = mepc_i;
        addr_mcause:   csr_rdata_o = mcause_i;
        addr_mtval:    csr_rdata_o = mtval_i;
        addr_mip:      csr_rdata_o = mip_i;

        // Machine counters and their user aliases
        addr_mcycle,
        addr_cycle:     csr_rdata_o = mcycle_i[xlen-1:0];
        addr_mcycleh,
        addr_cycleh:    csr_rdata_o = mcycle_i[63:xlen];
        addr_minstret,
        addr_instret:   csr_rdata_o = minstret_i[xlen-1:0];
        addr_minstreth,
        addr_instreth:  csr_rdata_o = minstret_i[63:xlen];
        default:        csr_rdata_o = '0;
      endcase
    end
  end

endmodule

// ==== rtl/csr_file.sv ====
/*
  Machine-mode CSR file
  Top level joining the event controller, the
  register groups and the read mux
*/
`timescale 1ns/1ps

module csr_file (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           rd_en_i,
  input  logic                           wr_en_i,
  input  logic [csr_pkg::csr_addr_w-1:0] csr_idx_i,
  input  logic [csr_pkg::xlen-1:0]       csr_wdata_i,
  output logic [csr_pkg::xlen-1:0]       csr_rdata_o,
  input  logic                           trap_i,
  input  logic                           mret_i,
  input  logic                           stall_i,
  input  logic [csr_pkg::xlen-1:0]       trap_cause_i,
  input  logic [csr_pkg::xlen-1:0]       trap_mepc_i,
  input  logic [csr_pkg::xlen-1:0]       trap_tval_i,
  input  logic                           timer_irq_i,
  input  logic                           sw_irq_i,
  input  logic                           ext_irq_i,
  output logic [csr_pkg::xlen-1:0]       mtvec_o,
  output logic [csr_pkg::xlen-1:0]       mepc_o,
  output logic                           misa_c_o
);
  import csr_pkg::*;

  logic            advance;  // Strobes from the event controller
  logic            csr_we;
  logic            retire;
  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mtval;
  logic [xlen-1:0] misa;
  logic [xlen-1:0] mie;
  logic [xlen-1:0] mscratch;
  logic [xlen-1:0] mip;
  logic [63:0]     mcycle;
  logic [63:0]     minstret;

  csr_event_ctrl u_event_ctrl (
    .clk_i, .rst_ni, .stall_i, .trap_i, .mret_i, .wr_en_i,
    .advance_o (advance),
    .csr_we_o  (csr_we),
    .retire_o  (retire)
  );

  csr_trap_regs u_trap_regs (
    .clk_i, .rst_ni, .advance_i (advance), .csr_we_i (csr_we), .trap_i, .mret_i,
    .csr_idx_i, .csr_wdata_i, .trap_cause_i, .trap_mepc_i, .trap_tval_i,
    .mstatus_o (mstatus), .mepc_o, .mcause_o (mcause), .mtval_o (mtval)
  );

  csr_setup_regs u_setup_regs (
    .clk_i, .rst_ni, .csr_we_i (csr_we), .csr_idx_i, .csr_wdata_i,
    .timer_irq_i, .sw_irq_i, .ext_irq_i,
    .misa_o (misa), .mie_o (mie), .mtvec_o, .mscratch_o (mscratch), .mip_o (mip)
  );

  csr_counters u_counters (
    .clk_i, .rst_ni, .advance_i (advance), .retire_i (retire), .csr_we_i (csr_we),
    .csr_idx_i, .csr_wdata_i, .mcycle_o (mcycle), .minstret_o (minstret)
  );

  csr_read_mux u_read_mux (
    .rd_en_i, .csr_idx_i, .mstatus_i (mstatus), .misa_i (misa), .mie_i (mie),
    .mip_i (mip), .mtvec_i (mtvec_o), .mscratch_i (mscratch), .mepc_i (mepc_o),
    .mcause_i (mcause), .mtval_i (mtval), .mcycle_i (mcycle), .minstret_i (minstret),
    .csr_rdata_o
  );

  assign misa_c_o = misa[2];  // Compressed extension enable

endmodule

// ==== verif/csr_file_assert.sv ====
/*
  CSR event strobe assertions
  Bound into csr_event_ctrl. Checks write exclusion,
  trap advance, quiet strobes in reset and event capture
*/
`timescale 1ns/1ps

module csr_file_assert (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                trap_i,
  input logic                mret_i,
  input logic                advance_i,
  input logic                csr_we_i,
  input logic                retire_i,
  input csr_pkg::csr_event_e last_event_i
);
  import csr_pkg::*;

  // Software write never shares a cycle with trap or mret
  we_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_we_i |-> !(trap_i || mret_i))
    else $error("csr_we_o high together with trap_i or mret_i");

  // Trap overrides a stall
  trap_advances: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trap_i |-> advance_i)
    else $error("advance_o low during trap_i");

  // All strobes quiet while reset is held
  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !(advance_i || csr_we_i || retire_i))
    else $error("strobe high during reset");

  trap_recorded: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trap_i |=> (last_event_i == ev_trap))
    else $error("trap not recorded as last event");

endmodule

// ==== include/csr_model.svh ====
/*
  CSR reference model
  Cycle model of every kept CSR for the testbench,
  stepped once per rising edge, with a read function
*/
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

logic        m_mie;  // mstatus.MIE
logic        m_mpie;
logic [31:0] m_misa;
logic [31:0] m_mie_reg;
logic [31:0] m_mtvec;
logic [31:0] m_mscratch;
logic [31:0] m_mepc;
logic [31:0] m_mcause;
logic [31:0] m_mtval;
logic [63:0] m_mcycle;
logic [63:0] m_minstret;

function automatic void model_reset();
  m_mie      = 1'b0;
  m_mpie     = 1'b0;
  m_misa     = 32'h4000_1104;  // RV32IMC
  m_mie_reg  = '0;
  m_mtvec    = '0;
  m_mscratch = '0;
  m_mepc     = '0;
  m_mcause   = '0;
  m_mtval    = '0;
  m_mcycle   = '0;
  m_minstret = '0;
endfunction

// One rising edge with the inputs the DUT saw
function automatic void model_step(input logic stall, input logic trap, input logic mret,
                                   input logic wr_en, input logic [11:0] idx,
                                   input logic [31:0] wdata, input logic [31:0] cause,
                                   input logic [31:0] epc, input logic [31:0] tval);
  logic        adv;
  logic        we;
  logic [63:0] cyc;
  adv = !stall || trap;
  we  = adv && wr_en && !trap && !mret;
  if (adv) begin
    cyc = m_mcycle + 64'd1;
    if (we && idx == csr_pkg::addr_mcycle) cyc[31:0] = wdata;
    if (we && idx == csr_pkg::addr_mcycleh) cyc[63:32] = wdata;
    m_mcycle = cyc;
  end
  if (we && idx == csr_pkg::addr_minstret) m_minstret[31:0] = wdata;
  else if (we && idx == csr_pkg::addr_minstreth) m_minstret[63:32] = wdata;
  else if (adv && !trap) m_minstret = m_minstret + 64'd1;
  if (trap) begin
    m_mepc   = epc;
    m_mcause = cause;
    m_mtval  = tval;
    m_mpie   = m_mie;
    m_mie    = 1'b0;
  end else if (adv && mret) begin
    m_mie  = m_mpie;
    m_mpie = 1'b1;
  end else if (we) begin
    case (idx)
      csr_pkg::addr_mstatus: begin
        m_mie  = wdata[3];
        m_mpie = wdata[7];
      end
      csr_pkg::addr_misa:     m_misa     = (m_misa & ~32'h4) | (wdata & 32'h4);
      csr_pkg::addr_mie:      m_mie_reg  = wdata & 32'h888;
      csr_pkg::addr_mtvec:    m_mtvec    = wdata;
      csr_pkg::addr_mscratch: m_mscratch = wdata;
      csr_pkg::addr_mepc:     m_mepc     = wdata;
      csr_pkg::addr_mcause:   m_mcause   = wdata;
      csr_pkg::addr_mtval:    m_mtval    = wdata;
      default: ;
    endcase
  end
endfunction

// Expected csr_rdata_o for the current model state
function automatic logic [31:0] model_read(input logic rd_en, input logic [11:0] idx,
                                           input logic t_irq, input logic s_irq,
                                           input logic e_irq);
  logic [31:0] mip;
  mip = {20'd0, e_irq, 3'd0, t_irq, 3'd0, s_irq, 3'd0};
  if (!rd_en) return '0;
  case (idx)
    csr_pkg::addr_marchid:  return 32'd5;
    csr_pkg::addr_mstatus:  return {19'd0, 2'b11, 3'd0, m_mpie, 3'd0, m_mie, 3'd0};
    csr_pkg::addr_misa:     return m_misa;
    csr_pkg::addr_mie:      return m_mie_reg;
    csr_pkg::addr_mtvec:    return m_mtvec;
    csr_pkg::addr_mscratch: return m_mscratch;
    csr_pkg::addr_mepc:     return m_mepc;
    csr_pkg::addr_mcause:   return m_mcause;
    csr_pkg::addr_mtval:    return m_mtval;
    csr_pkg::addr_mip:      return mip;
    csr_pkg::addr_mcycle,   csr_pkg::addr_cycle:    return m_mcycle[31:0];
    csr_pkg::addr_mcycleh,  csr_pkg::addr_cycleh:   return m_mcycle[63:32];
    csr_pkg::addr_minstret, csr_pkg::addr_instret:  return m_minstret[31:0];
    csr_pkg::addr_minstreth, csr_pkg::addr_instreth: return m_minstret[63:32];
    default:                return '0;  // Info regs, mstatush, unknown
  endcase
endfunction

`endif

// ==== verif/tb_csr_file.sv ====
/*
  CSR file testbench
  Drives the CSR file on the falling edge, steps the
  reference model on the rising edge and compares the
  read port and side outputs every cycle
*/
`timescale 1ns/1ps

module tb_csr_file;
  import csr_pkg::*;

  `include "csr_model.svh"

  localparam logic [15:0] lfsr_seed = 16'd39;
  localparam int unsigned len_reset = 16;  // Reset cycles
  localparam int unsigned len_rst_rd = 19;
  localparam int unsigned len_warl = 60;
  localparam int unsigned len_irq = 21;
  localparam int unsigned len_trap = 37;
  localparam int unsigned len_cnt = 214;
  localparam int unsigned timeout_cycles =
    len_reset + len_rst_rd + len_warl + len_irq + len_trap + len_cnt + 100;

  logic        clk = 1'b0;
  logic        rst_n, rd_en, wr_en, trap, mret, stall;
  logic [11:0] csr_idx;
  logic [31:0] wdata, cause, epc, tval;
  logic        t_irq, s_irq, e_irq;
  logic [31:0] rdata, mtvec, mepc;
  logic        misa_c;

  logic [15:0] lfsr_q = lfsr_seed;
  logic [2:0]  irq_lines = '0;  // {ext, sw, timer}
  logic [31:0] rnd;
  logic [31:0] exp_rdata;
  logic        chk_en = 1'b0;
  int unsigned err_cnt = 0;
  int unsigned err_mark = 0;   // Errors before the current test
  int unsigned n_checks = 0;
  int unsigned cycle_cnt = 0;

  csr_file dut (
    .clk_i (clk), .rst_ni (rst_n), .rd_en_i (rd_en), .wr_en_i (wr_en),
    .csr_idx_i (csr_idx), .csr_wdata_i (wdata), .csr_rdata_o (rdata),
    .trap_i (trap), .mret_i (mret), .stall_i (stall), .trap_cause_i (cause),
    .trap_mepc_i (epc), .trap_tval_i (tval), .timer_irq_i (t_irq),
    .sw_irq_i (s_irq), .ext_irq_i (e_irq), .mtvec_o (mtvec), .mepc_o (mepc),
    .misa_c_o (misa_c)
  );

  bind csr_event_ctrl csr_file_assert u_assert (
    .clk_i (clk_i), .rst_ni (rst_ni), .trap_i (trap_i), .mret_i (mret_i),
    .advance_i (advance_o), .csr_we_i (csr_we_o), .retire_i (retire_o),
    .last_event_i (last_event_q)
  );

  initial begin
    forever #4 clk = ~clk;  // 8 ns period
  end

  // ==================================================
  // Stimulus helpers
  // ==================================================
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11
  endfunction

  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[15]};
      lfsr_q = lfsr_step(lfsr_q);  // One step per bit
    end
    return v;
  endfunction

  // Fixed and WARL addresses, plus one unused address
  function automatic logic [11:0] warl_addr(input int unsigned i);
    case (i)
      0: return addr_mstatus;
      1: return addr_misa;
      2: return addr_mie;
      3: return addr_mtvec;
      4: return addr_mscratch;
      5: return addr_mepc;
      6: return addr_mcause;
      7: return addr_mtval;
      8: return addr_mip;
      9: return addr_marchid;
      10: return addr_mvendorid;
      11: return addr_mstatush;
      12: return addr_mhartid;
      default: return 12'h7C0;
    endcase
  endfunction

  function automatic logic [11:0] cnt_addr(input logic [2:0] i);
    case (i)
      3'd0: return addr_mcycle;
      3'd1: return addr_mcycleh;
      3'd2: return addr_minstret;
      3'd3: return addr_minstreth;
      3'd4: return addr_cycle;
      3'd5: return addr_cycleh;
      3'd6: return addr_instret;
      default: return addr_instreth;
    endcase
  endfunction

  // One falling-edge drive of every DUT input
  task automatic drive_cycle(input logic rd, wr, input logic [11:0] idx,
                             input logic [31:0] data, input logic trp, ret, stl);
    @(negedge clk);
    rd_en   = rd;
    wr_en   = wr;
    csr_idx = idx;
    wdata   = data;
    trap    = trp;
    mret    = ret;
    stall   = stl;
    t_irq   = irq_lines[0];
    s_irq   = irq_lines[1];
    e_irq   = irq_lines[2];
    if (trp) begin  // Fresh trap payload
      cause = take_bits(32);
      epc   = take_bits(32);
      tval  = take_bits(32);
    end
  endtask

  task automatic read_csr(input logic [11:0] idx);
    drive_cycle(1'b1, 1'b0, idx, 32'd0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic write_csr(input logic [11:0] idx, input logic [31:0] data);
    drive_cycle(1'b1, 1'b1, idx, data, 1'b0, 1'b0, 1'b0);
  endtask

  // Waits past the last compare, then reports
  task automatic finish_test(input string name);
    @(posedge clk);
    $display("test %-12s done, %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
    $display("[FAIL] %0t %s expected %h got %h", $time, name, exp_v, got_v);
    err_cnt++;
  endtask

  // ==================================================
  // Model step and compare
  // ==================================================
  always @(posedge clk) begin
    if (!rst_n) model_reset();
    else model_step(stall, trap, mret, wr_en, csr_idx, wdata, cause, epc, tval);
  end

  always @(negedge clk) begin
    #2;  // Mid low phase, inputs settled
    if (chk_en) begin
      exp_rdata = model_read(rd_en, csr_idx, t_irq, s_irq, e_irq);
      n_checks += 4;
      if (rdata !== exp_rdata) report_mismatch("csr_rdata_o", exp_rdata, rdata);
      if (mtvec !== m_mtvec) report_mismatch("mtvec_o", m_mtvec, mtvec);
      if (mepc !== m_mepc) report_mismatch("mepc_o", m_mepc, mepc);
      if (misa_c !== m_misa[2]) report_mismatch("misa_c_o", {31'd0, m_misa[2]}, {31'd0, misa_c});
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    rst_n = 1'b0;
    rd_en = 1'b0;
    wr_en = 1'b0;
    csr_idx = '0;
    wdata = '0;
    trap = 1'b0;
    mret = 1'b0;
    stall = 1'b1;  // Strobes stay low in reset
    cause = '0;
    epc = '0;
    tval = '0;
    t_irq = 1'b0;
    s_irq = 1'b0;
    e_irq = 1'b0;
    repeat (len_reset) @(negedge clk);
    rst_n = 1'b1;
    chk_en = 1'b1;

    // Reset values of every fixed and WARL address
    for (int unsigned i = 0; i < 14; i++) read_csr(warl_addr(i));
    read_csr(addr_mimpid);
    read_csr(addr_mconfigptr);
    read_csr(addr_mcycle);
    read_csr(addr_minstret);
    finish_test("reset");

    // Two passes of random writes with readback
    for (int unsigned p = 0; p < 2; p++) begin
      for (int unsigned i = 0; i < 14; i++) begin
        write_csr(warl_addr(i), take_bits(32));
        read_csr(warl_addr(i));
      end
    end
    write_csr(addr_misa, 32'h0);  // C off then on again
    write_csr(addr_misa, 32'hFFFF_FFFF);
    finish_test("warl");

    for (int unsigned i = 0; i < 20; i++) begin
      rnd = take_bits(3);
      irq_lines = rnd[2:0];
      read_csr(addr_mip);
    end
    irq_lines = '0;
    finish_test("irq");

    for (int unsigned i = 0; i < 4; i++) begin
      write_csr(addr_mstatus, take_bits(32) | 32'h8);  // MIE on
      // Trap with a write that must be dropped, stalled on odd rounds
      drive_cycle(1'b1, 1'b1, addr_mscratch, take_bits(32), 1'b1, 1'b0, i[0]);
      read_csr(addr_mepc);
      read_csr(addr_mcause);
      read_csr(addr_mtval);
      read_csr(addr_mstatus);
      drive_cycle(1'b1, 1'b1, addr_mstatus, 32'd0, 1'b0, 1'b1, 1'b0);
      read_csr(addr_mstatus);
      read_csr(addr_mscratch);
    end
    finish_test("trap_mret");

    // Low half close to wrap so the carry shows up
    write_csr(addr_mcycleh, 32'h0000_0007);
    write_csr(addr_mcycle, 32'hFFFF_FFF8);
    repeat (9) read_csr(addr_mcycleh);  // Carry lands on the last read
    for (int unsigned i = 0; i < 200; i++) begin
      rnd = take_bits(11);
      drive_cycle(1'b1, rnd[7:6] == 2'd0, cnt_addr(rnd[10:8]), take_bits(32),
                  rnd[3:1] == 3'd0, rnd[5:4] == 2'd0, rnd[0]);
    end
    read_csr(addr_mcycleh);
    finish_test("counters");

    chk_en = 1'b0;
    $display("Summary: %0d checks, %0d errors", n_checks, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
rtl/csr_pkg.sv
rtl/csr_event_ctrl.sv
rtl/csr_trap_regs.sv
rtl/csr_setup_regs.sv
rtl/csr_counters.sv
rtl/csr_read_mux.sv
rtl/csr_file.sv
verif/csr_file_assert.sv
verif/tb_csr_file.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CSR file testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_csr_file -f tb.f \
  -o sim_csr_file > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_csr_file > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log && exit 0 || { echo "No pass result in log"; exit 1; }
